// ==== run_sim.sh ====
#!/bin/sh
# Compiles the vector load unit testbench with Verilator and runs it.
# Exits non-zero on a build error, a crash, or a run without a pass.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vldu -Mdir "$OBJ" -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ/Vtb_vldu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim.f ====
+incdir+tb
src/vldu_pkg.sv
src/vldu_insn_queue.sv
src/vldu_beat_unpack.sv
src/vldu_result_queue.sv
src/vldu_top.sv
tb/tb_vldu.sv

// ==== src/vldu_beat_unpack.sv ====
//////////////////////////////////////////////////////////////////////
// Packs read beats into shuffled register-file words
// Bursts are incremental, only the first beat starts at an offset
// Bursts must end with their instruction, leftover beat bytes drop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vldu_beat_unpack (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  vldu_pkg::issue_info_t                issue_i,
  input  vldu_pkg::addrgen_req_t               burst_i,
  input  logic                                 burst_valid_i,
  output logic                                 burst_ready_o,
  input  logic [vldu_pkg::BeatBytes*8-1:0]     r_data_i,
  input  logic                                 r_valid_i,
  output logic                                 r_ready_o,
  input  logic                                 full_i,
  output logic                                 issue_done_o,
  output logic                                 push_o,
  output vldu_pkg::result_word_t               word_o
);

  // Beats consumed in the current burst
  logic [3:0]                                   len_d, len_q;
  // Bytes taken from the current beat, counted from its first valid byte
  logic [3:0]                                   r_pnt_d, r_pnt_q;
  // Bytes filled in the word being built
  logic [4:0]                                   word_pnt_d, word_pnt_q;
  // Index of the word inside the instruction
  logic [$clog2(vldu_pkg::RegWords)-1:0]        word_idx_d, word_idx_q;
  vldu_pkg::result_word_t                       word_d, word_q;

  logic            fire;
  logic            word_end;
  logic            beat_end;
  logic            ins_end;
  vldu_pkg::vlen_t lower_byte;
  vldu_pkg::vlen_t beat_left;
  vldu_pkg::vlen_t word_left;
  vldu_pkg::vlen_t ins_left;
  vldu_pkg::vlen_t take;

  // Sequential word byte to its lane and byte position
  function automatic logic [3:0] shuffle_idx(input logic [3:0] seq,
                                             input vldu_pkg::vsew_e vsew);
    logic [3:0] elem;
    logic [3:0] pos;
    elem = seq >> vsew;
    // Element pairs share a lane slot, byte order inside the element kept
    pos  = ((elem >> 1) << vsew) | (seq & ((4'd1 << vsew) - 4'd1));
    return {elem[0], pos[2:0]};
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Byte accounting
  ////////////////////////////////////////////////////////////////////

  assign fire = r_valid_i && burst_valid_i && issue_i.valid && !full_i;

  // Offset applies to the first beat of a burst only
  assign lower_byte = (len_q == '0) ? vldu_pkg::vlen_t'(burst_i.offset) : '0;
  assign beat_left  = vldu_pkg::vlen_t'(vldu_pkg::BeatBytes) - lower_byte -
                      vldu_pkg::vlen_t'(r_pnt_q);
  assign word_left  = vldu_pkg::vlen_t'(vldu_pkg::WordBytes) - vldu_pkg::vlen_t'(word_pnt_q);
  assign ins_left   = issue_i.bytes_left -
                      vldu_pkg::vlen_t'(word_idx_q) * vldu_pkg::vlen_t'(vldu_pkg::WordBytes) -
                      vldu_pkg::vlen_t'(word_pnt_q);

  // Smallest of beat, word and instruction remainders
  always_comb begin
    take = beat_left;
    if (word_left < take)
      take = word_left;
    if (ins_left < take)
      take = ins_left;
  end

  assign ins_end  = fire && (take == ins_left);
  assign word_end = fire && ((take == word_left) || ins_end);
  assign beat_end = fire && ((take == beat_left) || ins_end);

  assign r_ready_o     = beat_end;
  assign burst_ready_o = beat_end && (len_q == burst_i.len);
  assign issue_done_o  = ins_end;
  assign push_o        = word_end;
  // Pushed word carries this cycle's bytes
  assign word_o        = word_d;

  ////////////////////////////////////////////////////////////////////
  // Word assembly
  ////////////////////////////////////////////////////////////////////

  always_comb begin : p_pack
    int unsigned          first;
    logic [3:0]           dst;
    vldu_pkg::lane_addr_t lane;
    first  = int'(lower_byte) + int'(r_pnt_q);
    dst    = '0;
    lane   = '0;
    word_d = word_q;
    if (fire) begin
      for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
        word_d[l].id   = issue_i.req.id;
        word_d[l].addr = vldu_pkg::vaddr_t'(issue_i.req.vd * vldu_pkg::RegWords + word_idx_q);
      end
      for (int k = 0; k < vldu_pkg::BeatBytes; k++) begin
        if (k >= first && k < first + int'(take)) begin
          dst  = shuffle_idx(4'(k - first + int'(word_pnt_q)), issue_i.req.vsew);
          lane = vldu_pkg::lane_addr_t'(dst[3]);
          word_d[lane].wdata[8*dst[2:0] +: 8] = r_data_i[8*k +: 8];
          word_d[lane].be[dst[2:0]]           = 1'b1;
        end
      end
    end
  end

  always_comb begin
    len_d      = len_q;
    r_pnt_d    = r_pnt_q;
    word_pnt_d = word_pnt_q;
    word_idx_d = word_idx_q;
    if (fire) begin
      r_pnt_d    = r_pnt_q + take[3:0];
      word_pnt_d = word_pnt_q + take[4:0];
    end
    if (word_end) begin
      word_pnt_d = '0;
      word_idx_d = word_idx_q + 1'b1;
    end
    if (ins_end)
      word_idx_d = '0;
    if (beat_end) begin
      r_pnt_d = '0;
      len_d   = len_q + 1'b1;
    end
    if (burst_ready_o)
      len_d = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_q      <= '0;
      r_pnt_q    <= '0;
      word_pnt_q <= '0;
      word_idx_q <= '0;
      word_q     <= '0;
    end else begin
      len_q      <= len_d;
      r_pnt_q    <= r_pnt_d;
      word_pnt_q <= word_pnt_d;
      word_idx_q <= word_idx_d;
      // Start the next word with all byte enables low
      word_q     <= word_end ? '0 : word_d;
    end
  end

endmodule

// ==== src/vldu_insn_queue.sv ====
//////////////////////////////////////////////////////////////////////
// Load instruction queue with accept, issue and commit phases
// Every instruction needs vl > 0, a zero byte count retires at once
// done_o is registered, one cycle after the emptying pop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vldu_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vldu_pkg::ldu_req_t    req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output vldu_pkg::issue_info_t issue_o,
  input  logic                  issue_done_i,
  input  logic                  pop_i,
  output logic                  done_o,
  output vldu_pkg::vid_t        done_id_o
);

  // Stored instructions, written on accept
  vldu_pkg::ldu_req_t mem_q [vldu_pkg::InsnQueueDepth];

  // One pointer per phase
  logic [$clog2(vldu_pkg::InsnQueueDepth)-1:0] accept_pnt_q;
  logic [$clog2(vldu_pkg::InsnQueueDepth)-1:0] issue_pnt_d, issue_pnt_q;
  logic [$clog2(vldu_pkg::InsnQueueDepth)-1:0] commit_pnt_d, commit_pnt_q;
  // Entries waiting for issue, and entries not yet committed
  logic [$clog2(vldu_pkg::InsnQueueDepth):0]   issue_cnt_d, issue_cnt_q;
  logic [$clog2(vldu_pkg::InsnQueueDepth):0]   commit_cnt_d, commit_cnt_q;
  // Byte counts of the issuing and the committing instruction
  vldu_pkg::vlen_t                             issue_bytes_d, issue_bytes_q;
  vldu_pkg::vlen_t                             commit_bytes_d, commit_bytes_q;

  logic accept;
  logic retire;

  // Bytes moved by one instruction, vl scaled by element width
  function automatic vldu_pkg::vlen_t insn_bytes(input vldu_pkg::ldu_req_t req);
    return req.vl << req.vsew;
  endfunction

  // Commit count covers every stored entry
  assign req_ready_o = (commit_cnt_q != vldu_pkg::InsnQueueDepth);
  assign accept      = req_valid_i && req_ready_o;

  assign issue_o.valid      = (issue_cnt_q != '0);
  assign issue_o.req        = mem_q[issue_pnt_q];
  assign issue_o.bytes_left = issue_bytes_q;

  always_comb begin
    issue_pnt_d    = issue_pnt_q;
    commit_pnt_d   = commit_pnt_q;
    issue_cnt_d    = issue_cnt_q;
    commit_cnt_d   = commit_cnt_q;
    issue_bytes_d  = issue_bytes_q;
    commit_bytes_d = commit_bytes_q;
    retire         = 1'b0;

    // Issue phase, unpacker took the last byte
    if (issue_done_i) begin
      issue_cnt_d = issue_cnt_q - 1'b1;
      issue_pnt_d = issue_pnt_q + 1'b1;
      // Load the byte count of the next stored entry
      if (issue_cnt_d != '0)
        issue_bytes_d = insn_bytes(mem_q[issue_pnt_d]);
    end

    // Commit phase, one word left the result queue
    if (pop_i) begin
      if (commit_bytes_q > vldu_pkg::WordBytes)
        commit_bytes_d = commit_bytes_q - vldu_pkg::vlen_t'(vldu_pkg::WordBytes);
      else
        commit_bytes_d = '0;
    end

    // All words of the oldest instruction are in the lanes
    if (commit_cnt_q != '0 && commit_bytes_d == '0) begin
      retire       = 1'b1;
      commit_cnt_d = commit_cnt_q - 1'b1;
      commit_pnt_d = commit_pnt_q + 1'b1;
      if (commit_cnt_d != '0)
        commit_bytes_d = insn_bytes(mem_q[commit_pnt_d]);
    end

    // Accept, counts load straight from the request when the phase is idle
    if (accept) begin
      if (issue_cnt_d == '0)
        issue_bytes_d = insn_bytes(req_i);
      if (commit_cnt_d == '0)
        commit_bytes_d = insn_bytes(req_i);
      issue_cnt_d  = issue_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  // Instruction storage
  always_ff @(posedge clk_i) begin
    if (accept)
      mem_q[accept_pnt_q] <= req_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      issue_bytes_q  <= '0;
      commit_bytes_q <= '0;
      done_o         <= 1'b0;
      done_id_o      <= '0;
    end else begin
      if (accept)
        accept_pnt_q <= accept_pnt_q + 1'b1;
      issue_pnt_q    <= issue_pnt_d;
      commit_pnt_q   <= commit_pnt_d;
      issue_cnt_q    <= issue_cnt_d;
      commit_cnt_q   <= commit_cnt_d;
      issue_bytes_q  <= issue_bytes_d;
      commit_bytes_q <= commit_bytes_d;
      done_o         <= retire;
      done_id_o      <= mem_q[commit_pnt_q].id;
    end
  end

endmodule

// ==== src/vldu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, enums and structs of the vector load unit
// Queue depths must stay powers of two, pointers wrap naturally
// Lane word addresses are 5 bits, so vd is limited to 0..7
//////////////////////////////////////////////////////////////////////

package vldu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and depths
  //////////////////////////////////////////////////////////////////////

  // Lanes of the vector register file
  localparam int unsigned NrLanes          = 2;
  // Bytes per lane word
  localparam int unsigned LaneBytes        = 8;
  // Bytes per register-file word, one lane word per lane
  localparam int unsigned WordBytes        = NrLanes * LaneBytes;
  // Bytes per read beat
  localparam int unsigned BeatBytes        = 8;
  // Bytes in one vector register
  localparam int unsigned VlenBytes        = 64;
  // Lane words per register
  localparam int unsigned RegWords         = VlenBytes / WordBytes;
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  // Instruction identifiers in flight across the machine
  localparam int unsigned NrVInsn          = 8;

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef logic [$clog2(NrVInsn)-1:0]   vid_t;
  // Holds up to VlenBytes inclusive
  typedef logic [$clog2(VlenBytes):0]   vlen_t;
  typedef logic [4:0]                   vaddr_t;
  // Lane index of a shuffled byte
  typedef logic [$clog2(NrLanes)-1:0]   lane_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // Load instruction from the sequencer
  typedef struct packed {
    vid_t       id;
    logic [4:0] vd;
    vlen_t      vl;
    vsew_e      vsew;
  } ldu_req_t;

  // Burst descriptor from the address generator
  typedef struct packed {
    // Start byte inside the first beat
    logic [$clog2(BeatBytes)-1:0] offset;
    // Beats minus one
    logic [3:0]                   len;
  } addrgen_req_t;

  // One write into one lane
  typedef struct packed {
    vid_t                   id;
    vaddr_t                 addr;
    logic [LaneBytes*8-1:0] wdata;
    logic [LaneBytes-1:0]   be;
  } lane_result_t;

  // Full register-file word, one write per lane
  typedef lane_result_t [NrLanes-1:0] result_word_t;

  // Instruction currently in the issue phase
  typedef struct packed {
    logic     valid;
    ldu_req_t req;
    // Byte count of the instruction when it reached issue
    vlen_t    bytes_left;
  } issue_info_t;

endpackage

// ==== src/vldu_result_queue.sv ====
//////////////////////////////////////////////////////////////////////
// Two-entry result queue, each lane granted independently
// Pushes are only legal while full_o is low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vldu_result_queue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  vldu_pkg::result_word_t        word_i,
  output logic                          full_o,
  output logic                          pop_o,
  output logic [vldu_pkg::NrLanes-1:0]  lane_req_o,
  output vldu_pkg::result_word_t        lane_result_o,
  input  logic [vldu_pkg::NrLanes-1:0]  lane_gnt_i
);

  // Word storage
  vldu_pkg::result_word_t mem_q [vldu_pkg::ResultQueueDepth];

  // Lanes still owed each entry
  logic [vldu_pkg::ResultQueueDepth-1:0][vldu_pkg::NrLanes-1:0] valid_d, valid_q;
  logic [$clog2(vldu_pkg::ResultQueueDepth)-1:0]                wr_pnt_q;
  logic [$clog2(vldu_pkg::ResultQueueDepth)-1:0]                rd_pnt_q;
  logic [$clog2(vldu_pkg::ResultQueueDepth):0]                  cnt_d, cnt_q;

  assign full_o = (cnt_q == vldu_pkg::ResultQueueDepth);

  // Head entry faces the lanes
  assign lane_req_o    = valid_q[rd_pnt_q];
  assign lane_result_o = mem_q[rd_pnt_q];

  always_comb begin
    valid_d = valid_q;
    cnt_d   = cnt_q;

    // A grant frees that lane's slot
    for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
      if (lane_req_o[l] && lane_gnt_i[l])
        valid_d[rd_pnt_q][l] = 1'b0;
    end

    // Pop once the last lane took the head
    pop_o = (cnt_q != '0) && (valid_d[rd_pnt_q] == '0);

    // New word waits for every lane, never lands on the head slot
    if (push_i)
      valid_d[wr_pnt_q] = '1;

    if (push_i && !pop_o)
      cnt_d = cnt_q + 1'b1;
    else if (!push_i && pop_o)
      cnt_d = cnt_q - 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (push_i)
      mem_q[wr_pnt_q] <= word_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      cnt_q   <= cnt_d;
      if (push_i)
        wr_pnt_q <= wr_pnt_q + 1'b1;
      if (pop_o)
        rd_pnt_q <= rd_pnt_q + 1'b1;
    end
  end

endmodule

// ==== src/vldu_top.sv ====
//////////////////////////////////////////////////////////////////////
// Vector load unit, sequencer and memory in, lane writes out
// r_ready_o is combinational on r_valid_i and burst_valid_i
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module vldu_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Sequencer
  input  vldu_pkg::ldu_req_t                req_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  // Address generator
  input  vldu_pkg::addrgen_req_t            burst_i,
  input  logic                              burst_valid_i,
  output logic                              burst_ready_o,
  // Read data
  input  logic [vldu_pkg::BeatBytes*8-1:0]  r_data_i,
  input  logic                              r_valid_i,
  output logic                              r_ready_o,
  // Lanes
  output logic [vldu_pkg::NrLanes-1:0]      lane_req_o,
  output vldu_pkg::result_word_t            lane_result_o,
  input  logic [vldu_pkg::NrLanes-1:0]      lane_gnt_i,
  // Completion
  output logic                              done_o,
  output vldu_pkg::vid_t                    done_id_o
);

  vldu_pkg::issue_info_t  issue;
  logic                   issue_done;
  logic                   push;
  vldu_pkg::result_word_t word;
  logic                   full;
  logic                   pop;

  // Accept, issue and commit bookkeeping
  vldu_insn_queue i_insn_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .issue_o      (issue),
    .issue_done_i (issue_done),
    .pop_i        (pop),
    .done_o       (done_o),
    .done_id_o    (done_id_o)
  );

  // Beat to word packing, stalls on a full result queue
  vldu_beat_unpack i_beat_unpack (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue),
    .burst_i       (burst_i),
    .burst_valid_i (burst_valid_i),
    .burst_ready_o (burst_ready_o),
    .r_data_i      (r_data_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .full_i        (full),
    .issue_done_o  (issue_done),
    .push_o        (push),
    .word_o        (word)
  );

  vldu_result_queue i_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (push),
    .word_i        (word),
    .full_o        (full),
    .pop_o         (pop),
    .lane_req_o    (lane_req_o),
    .lane_result_o (lane_result_o),
    .lane_gnt_i    (lane_gnt_i)
  );

endmodule

// ==== tb/tb_vldu_ref.svh ====
//////////////////////////////////////////////////////////////////////
// Reference model of the load unit, included inside tb_vldu
// Needs load_desc_t, each load uses one burst from an 8-byte base
//////////////////////////////////////////////////////////////////////

// Memory image, every address bit feeds the byte value
function automatic logic [7:0] mem_byte(input logic [31:0] addr);
  logic [31:0] h;
  h = addr * 32'h9e37_79b1;
  return h[31:24] ^ addr[7:0];
endfunction

// One read beat from an aligned address
function automatic logic [63:0] beat_data(input logic [31:0] addr);
  logic [63:0] data;
  for (int k = 0; k < vldu_pkg::BeatBytes; k++)
    data[8*k +: 8] = mem_byte(addr + 32'(k));
  return data;
endfunction

// Element index picks the lane
function automatic int shuffle_lane(input int b, input int sew);
  return (b >> sew) % vldu_pkg::NrLanes;
endfunction

// Slot of the element pair, then the byte inside the element
function automatic int shuffle_pos(input int b, input int sew);
  return (((b >> sew) / vldu_pkg::NrLanes) << sew) + (b % (1 << sew));
endfunction

function automatic int load_bytes(input load_desc_t d);
  return int'(d.req.vl) << int'(d.req.vsew);
endfunction

// Beats minus one, the burst ends with the load
function automatic logic [3:0] burst_len(input load_desc_t d);
  return 4'((int'(d.offset) + load_bytes(d) + 7) / 8 - 1);
endfunction

// Expected lane writes for word w of a load
function automatic vldu_pkg::result_word_t expected_word(input load_desc_t d, input int w);
  vldu_pkg::result_word_t word;
  int seq;
  int lane;
  int pos;
  word = '0;
  for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
    word[l].id   = d.req.id;
    word[l].addr = vldu_pkg::vaddr_t'(int'(d.req.vd) * vldu_pkg::RegWords + w);
  end
  for (int b = 0; b < vldu_pkg::WordBytes; b++) begin
    seq = w * vldu_pkg::WordBytes + b;
    // Bytes past the end keep be low
    if (seq < load_bytes(d)) begin
      lane = shuffle_lane(b, int'(d.req.vsew));
      pos  = shuffle_pos(b, int'(d.req.vsew));
      word[lane].wdata[8*pos +: 8] = mem_byte(d.base + 32'(d.offset) + 32'(seq));
      word[lane].be[pos]           = 1'b1;
    end
  end
  return word;
endfunction

// ==== tb/tb_vldu.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench of the vector load unit with one burst per load
// Lanes grant at once or at random and data comes from a fixed image
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_vldu;

  localparam int unsigned ClkPeriodNs   = 8;
  // Bound on words over all tests, and on cycles per word with slow grants
  localparam int unsigned WordsBound    = 60;
  localparam int unsigned CyclesPerWord = 100;
  localparam int unsigned WatchdogNs    = WordsBound * CyclesPerWord * ClkPeriodNs + 2000;

  // One load with its burst
  typedef struct packed {
    vldu_pkg::ldu_req_t req;
    logic [2:0]         offset;
    logic [31:0]        base;
  } load_desc_t;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  vldu_pkg::ldu_req_t            req_i;
  logic                          req_valid_i;
  logic                          req_ready_o;
  vldu_pkg::addrgen_req_t        burst_i;
  logic                          burst_valid_i;
  logic                          burst_ready_o;
  logic [63:0]                   r_data_i;
  logic                          r_valid_i;
  logic                          r_ready_o;
  logic [vldu_pkg::NrLanes-1:0]  lane_req_o;
  vldu_pkg::result_word_t        lane_result_o;
  logic [vldu_pkg::NrLanes-1:0]  lane_gnt_i;
  logic                          done_o;
  vldu_pkg::vid_t                done_id_o;

  load_desc_t                    loads[$];
  vldu_pkg::result_word_t        exp_words[$];
  // Ids accepted and not yet reported done
  vldu_pkg::vid_t                accepted_ids[$];
  logic [vldu_pkg::NrLanes-1:0]  granted;
  bit                            slow_grant;
  bit                            stall_seen;
  int                            done_cnt;
  // Words known complete from consumed beats, and words granted by all lanes
  int                            words_built;
  int                            words_taken;
  int                            checks;
  int                            errors;
  int                            tests;

  `include "tb_vldu_ref.svh"

  vldu_top i_dut (.*);

  always #(ClkPeriodNs / 2) clk_i = ~clk_i;

  task automatic check(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("[FAIL] t=%0t %s", $time, msg);
      errors++;
    end
  endtask

  // Data only counts where be is set
  function automatic bit same_write(input vldu_pkg::lane_result_t got,
                                    input vldu_pkg::lane_result_t exp);
    bit ok;
    ok = (got.id == exp.id) && (got.addr == exp.addr) && (got.be == exp.be);
    for (int k = 0; k < vldu_pkg::LaneBytes; k++)
      if (exp.be[k] && got.wdata[8*k +: 8] != exp.wdata[8*k +: 8])
        ok = 1'b0;
    return ok;
  endfunction

  // Words of a load whose last byte lies in the first beats read
  function automatic int words_read(input load_desc_t d, input int beats);
    int got;
    got = 8 * beats - int'(d.offset);
    if (got >= load_bytes(d))
      return (load_bytes(d) + 15) / 16;
    return got / 16;
  endfunction

  task automatic add_load(input int id, input int vd, input int vl,
                          input vldu_pkg::vsew_e sew, input int offset);
    load_desc_t d;
    d.req.id   = vldu_pkg::vid_t'(id);
    d.req.vd   = 5'(vd);
    d.req.vl   = vldu_pkg::vlen_t'(vl);
    d.req.vsew = sew;
    d.offset   = 3'(offset);
    d.base     = $urandom & 32'hffff_fff8;
    loads.push_back(d);
    for (int w = 0; w < (load_bytes(d) + 15) / 16; w++)
      exp_words.push_back(expected_word(d, w));
  endtask

  // Sequencer that holds each request until taken
  task automatic feed_requests();
    for (int i = 0; i < loads.size(); i++) begin
      req_i       = loads[i].req;
      req_valid_i = 1'b1;
      do begin
        @(negedge clk_i);
      end while (!req_ready_o);
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b0;
  endtask

  // Address generator and read channel with one burst per load
  task automatic feed_bursts();
    int beat;
    int words_before;
    bit took;
    bit last;
    for (int i = 0; i < loads.size(); i++) begin
      burst_i.offset = loads[i].offset;
      burst_i.len    = burst_len(loads[i]);
      burst_valid_i  = 1'b1;
      beat           = 0;
      last           = 1'b0;
      words_before   = words_built;
      while (!last) begin
        r_data_i  = beat_data(loads[i].base + 32'(8 * beat));
        r_valid_i = 1'b1;
        @(negedge clk_i);
        took = r_ready_o;
        last = burst_ready_o;
        @(posedge clk_i);
        #1;
        // The beat went in at this edge
        if (took) begin
          beat++;
          words_built = words_before + words_read(loads[i], beat);
        end
      end
      check(beat == int'(burst_len(loads[i])) + 1,
            $sformatf("burst of load %0d ended after %0d beats", loads[i].req.id, beat));
    end
    burst_valid_i = 1'b0;
    r_valid_i     = 1'b0;
  endtask

  task automatic run_test(input string name, input bit slow, input bit expect_stall);
    int errors_before;
    errors_before = errors;
    slow_grant    = slow;
    stall_seen    = 1'b0;
    done_cnt      = 0;
    @(posedge clk_i);
    #1;
    fork
      feed_requests();
      feed_bursts();
    join
    while (done_cnt < loads.size())
      @(posedge clk_i);
    @(negedge clk_i);
    check(exp_words.size() == 0, "some lane writes never arrived");
    if (expect_stall)
      check(stall_seen, "req_ready_o never fell with four loads queued");
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" :
             $sformatf("%0d errors", errors - errors_before));
    loads.delete();
  endtask

  // Lane models grant at once, or at random when grants are slow
  always begin
    @(posedge clk_i);
    #1;
    for (int l = 0; l < vldu_pkg::NrLanes; l++)
      lane_gnt_i[l] = lane_req_o[l] && (!slow_grant || $urandom_range(3, 0) == 0);
  end

  // Comparator samples at the falling edge where all outputs are settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (done_o) begin
        if (accepted_ids.size() == 0) begin
          check(1'b0, "done_o rose with no load in flight");
        end else begin
          check(done_id_o == accepted_ids[0],
                $sformatf("done id %0d, expected %0d", done_id_o, accepted_ids[0]));
          void'(accepted_ids.pop_front());
        end
        done_cnt++;
      end
      // Ready whenever fewer than four loads are in flight
      check(req_ready_o == (accepted_ids.size() < vldu_pkg::InsnQueueDepth),
            $sformatf("req_ready_o %0b with %0d loads in flight", req_ready_o,
                      accepted_ids.size()));
      if (req_valid_i && req_ready_o)
        accepted_ids.push_back(req_i.id);
      if (req_valid_i && !req_ready_o)
        stall_seen = 1'b1;
      // Words still waiting before this cycle's grants
      if (r_ready_o)
        check(words_built - words_taken < int'(vldu_pkg::ResultQueueDepth),
              $sformatf("r_ready_o high while %0d words wait ungranted",
                        words_built - words_taken));
      for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
        if (lane_req_o[l] && lane_gnt_i[l]) begin
          if (exp_words.size() == 0)
            check(1'b0, "lane write arrived with none expected");
          else
            check(same_write(lane_result_o[l], exp_words[0][l]),
                  $sformatf("lane %0d got id %0d addr %0d be %h data %h, exp %0d %0d %h %h",
                            l, lane_result_o[l].id, lane_result_o[l].addr,
                            lane_result_o[l].be, lane_result_o[l].wdata,
                            exp_words[0][l].id, exp_words[0][l].addr,
                            exp_words[0][l].be, exp_words[0][l].wdata));
          granted[l] = 1'b1;
        end
      end
      // Word done once every lane took it
      if (granted == '1) begin
        granted = '0;
        words_taken++;
        if (exp_words.size() != 0)
          void'(exp_words.pop_front());
      end
    end
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hd6a3));
    rst_ni        = 1'b0;
    req_i         = '0;
    req_valid_i   = 1'b0;
    burst_i       = '0;
    burst_valid_i = 1'b0;
    r_data_i      = '0;
    r_valid_i     = 1'b0;
    lane_gnt_i    = '0;
    granted       = '0;
    slow_grant    = 1'b0;
    words_built   = 0;
    words_taken   = 0;
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    check(req_ready_o && !r_ready_o && !burst_ready_o && lane_req_o == '0 && !done_o,
          "outputs not idle after reset");

    add_load(1, 2, 8, vldu_pkg::EW64, 0);
    run_test("ew64 aligned", 1'b0, 1'b0);

    add_load(2, 1, 40, vldu_pkg::EW8, 0);
    add_load(3, 3, 16, vldu_pkg::EW16, 0);
    add_load(4, 5, 12, vldu_pkg::EW32, 0);
    run_test("ew8 ew16 ew32 shuffle", 1'b0, 1'b0);

    add_load(5, 4, 13, vldu_pkg::EW16, 3);
    add_load(6, 6, 37, vldu_pkg::EW8, 5);
    run_test("offset and partial word", 1'b0, 1'b0);

    add_load(7, 0, 16, vldu_pkg::EW32, 0);
    add_load(0, 7, 45, vldu_pkg::EW8, 6);
    add_load(1, 2, 9, vldu_pkg::EW16, 1);
    add_load(2, 3, 5, vldu_pkg::EW64, 0);
    run_test("random lane grants", 1'b1, 1'b0);

    // First load is long, so the fifth finds the queue full
    add_load(3, 0, 8, vldu_pkg::EW64, 0);
    add_load(4, 1, 16, vldu_pkg::EW32, 2);
    add_load(5, 2, 32, vldu_pkg::EW16, 0);
    add_load(6, 3, 64, vldu_pkg::EW8, 7);
    add_load(7, 4, 8, vldu_pkg::EW64, 4);
    run_test("five back to back", 1'b0, 1'b1);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
